/* mem_msg_pkg.sv */
package mem_msg_pkg;

  // Physical address and message payload
  typedef logic [31:0] paddr_t;
  typedef logic [63:0] data_t;

  // Requester id, selects the response queue
  typedef logic [1:0] lce_id_t;

  typedef enum logic [0:0]
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } msg_type_e;

  // 35-bit header
  typedef struct packed
  {
    msg_type_e msg_type;
    lce_id_t   lce_id;
    paddr_t    addr;
  } mem_hdr_t;

  // 99-bit message, same layout for commands and responses
  typedef struct packed
  {
    mem_hdr_t header;
    data_t    data;
  } mem_msg_t;

endpackage

/* mem_map_pkg.sv */
package mem_map_pkg;
  import mem_msg_pkg::*;

  // Everything at or above this address is memory
  localparam paddr_t dram_base_c = 32'h8000_0000;

  // Device field of a local address
  localparam int dev_lsb_c = 20;
  typedef logic [3:0] dev_id_t;

  localparam dev_id_t host_dev_c  = 4'd1;
  localparam dev_id_t cache_dev_c = 4'd2;
  localparam dev_id_t clint_dev_c = 4'd3;

  // Clint register offsets, from address bits 15:0
  typedef logic [15:0] clint_off_t;

  localparam clint_off_t msip_off_c     = 16'h0000;
  localparam clint_off_t mtimecmp_off_c = 16'h4000;
  localparam clint_off_t mtime_off_c    = 16'hbff8;

endpackage

/* two_fifo.sv */
`timescale 1ns/1ps

module two_fifo
  #(parameter int width_p = 8)
  (  input                      clk_i
   , input                      rst_n_i

   , input        [width_p-1:0] data_i
   , input                      v_i
   , output logic               ready_o

   , output logic [width_p-1:0] data_o
   , output logic               v_o
   , input                      yumi_i
   );

  logic [1:0][width_p-1:0] mem_r;
  logic rd_ptr_r, wr_ptr_r, full_r;
  logic enq, deq, empty;

  assign enq   = v_i & ready_o;
  assign deq   = yumi_i;
  assign empty = (rd_ptr_r == wr_ptr_r) & ~full_r;

  assign ready_o = ~full_r;
  assign v_o     = ~empty;
  assign data_o  = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rd_ptr_r <= 1'b0;
      wr_ptr_r <= 1'b0;
      full_r   <= 1'b0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= ~wr_ptr_r;
      if (deq)
        rd_ptr_r <= ~rd_ptr_r;
      // Full once the write pointer catches up with the read pointer
      if (enq & ~deq)
        full_r <= (~wr_ptr_r == rd_ptr_r);
      else if (deq & ~enq)
        full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wr_ptr_r] <= data_i;
  end

endmodule

/* req_ingress.sv */
`timescale 1ns/1ps

module req_ingress
  import mem_msg_pkg::*;
  #(parameter int num_req_p = 3)
  (  input                                clk_i
   , input                                rst_n_i

   , input  mem_msg_t [num_req_p-1:0]     req_cmd_i
   , input            [num_req_p-1:0]     req_cmd_v_i
   , output logic     [num_req_p-1:0]     req_cmd_ready_o

   , output mem_msg_t                     grant_cmd_o
   , output logic                         grant_v_o
   , input                                dest_ready_i
   );

  mem_msg_t [num_req_p-1:0] head;
  logic [num_req_p-1:0] head_v;
  logic [num_req_p-1:0] pick, grant;

  for (genvar i = 0; i < num_req_p; i++)
  begin : cmd_q
    two_fifo
      #(.width_p($bits(mem_msg_t)))
      cmd_fifo
      (.clk_i(clk_i)
       ,.rst_n_i(rst_n_i)

       ,.data_i(req_cmd_i[i])
       ,.v_i(req_cmd_v_i[i])
       ,.ready_o(req_cmd_ready_o[i])

       ,.data_o(head[i])
       ,.v_o(head_v[i])
       ,.yumi_i(grant[i])
       );
  end

  // Lowest index wins, so scan from the top and let later hits override
  always_comb
  begin
    pick = '0;
    grant_cmd_o = '0;
    for (int i = num_req_p-1; i >= 0; i--)
    begin
      if (head_v[i])
      begin
        pick = '0;
        pick[i] = 1'b1;
        grant_cmd_o = head[i];
      end
    end
  end

  // Any blocked destination holds every queue
  assign grant     = pick & {num_req_p{dest_ready_i}};
  assign grant_v_o = |grant;

endmodule

/* cmd_dispatch.sv */
`timescale 1ns/1ps

module cmd_dispatch
  import mem_msg_pkg::*;
  import mem_map_pkg::*;
  (  input               cmd_v_i
   , input  paddr_t      cmd_addr_i

   , input               clint_ready_i
   , input               loop_ready_i
   , input               io_ready_i
   , input               mem_ready_i

   , output logic        clint_v_o
   , output logic        loop_v_o
   , output logic        io_v_o
   , output logic        mem_v_o

   , output logic        dest_ready_o
   );

  logic local_cmd;
  dev_id_t dev;
  logic is_clint, is_io, is_mem, is_loop;

  assign local_cmd = (cmd_addr_i < dram_base_c);
  assign dev       = cmd_addr_i[dev_lsb_c +: $bits(dev_id_t)];

  assign is_clint = local_cmd & (dev == clint_dev_c);
  assign is_io    = local_cmd & (dev == host_dev_c);
  // Local cache window is served by memory as well
  assign is_mem   = ~local_cmd | (dev == cache_dev_c);
  assign is_loop  = local_cmd & ~is_clint & ~is_io & (dev != cache_dev_c);

  assign clint_v_o = cmd_v_i & is_clint;
  assign loop_v_o  = cmd_v_i & is_loop;
  assign io_v_o    = cmd_v_i & is_io;
  assign mem_v_o   = cmd_v_i & is_mem;

  assign dest_ready_o = clint_ready_i & loop_ready_i & io_ready_i & mem_ready_i;

endmodule

/* clint_slice.sv */
`timescale 1ns/1ps

module clint_slice
  import mem_msg_pkg::*;
  import mem_map_pkg::*;
  (  input                clk_i
   , input                rst_n_i

   , input  mem_msg_t     cmd_i
   , input                cmd_v_i
   , output logic         cmd_ready_o

   , output mem_msg_t     resp_o
   , output logic         resp_v_o
   , input                resp_yumi_i

   , output logic         timer_irq_o
   , output logic         software_irq_o
   );

  logic [63:0] mtime_r, mtimecmp_r;
  logic msip_r;

  mem_msg_t resp_r;
  logic resp_v_r;

  clint_off_t off;
  logic cmd_fire, is_wr;
  data_t rd_data;

  // One response in flight at a time
  assign cmd_ready_o = ~resp_v_r;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;
  assign off         = cmd_i.header.addr[15:0];
  assign is_wr       = (cmd_i.header.msg_type == e_mem_wr);

  always_comb
  begin
    case (off)
      msip_off_c:     rd_data = {63'b0, msip_r};
      mtimecmp_off_c: rd_data = mtimecmp_r;
      mtime_off_c:    rd_data = mtime_r;
      default:        rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mtime_r    <= '0;
      mtimecmp_r <= '1;
      msip_r     <= 1'b0;
      resp_v_r   <= 1'b0;
    end
    else
    begin
      mtime_r <= mtime_r + 64'd1;
      // A write to mtime overrides the increment
      if (cmd_fire & is_wr)
      begin
        case (off)
          msip_off_c:     msip_r     <= cmd_i.data[0];
          mtimecmp_off_c: mtimecmp_r <= cmd_i.data;
          mtime_off_c:    mtime_r    <= cmd_i.data;
          default:        ;
        endcase
      end
      if (cmd_fire)
        resp_v_r <= 1'b1;
      else if (resp_yumi_i)
        resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_r.header <= cmd_i.header;
      resp_r.data   <= is_wr ? '0 : rd_data;
    end
  end

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;

  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = msip_r;

endmodule

/* loopback_dev.sv */
`timescale 1ns/1ps

module loopback_dev
  import mem_msg_pkg::*;
  (  input                clk_i
   , input                rst_n_i

   , input  mem_hdr_t     cmd_i
   , input                cmd_v_i
   , output logic         cmd_ready_o

   , output mem_msg_t     resp_o
   , output logic         resp_v_o
   , input                resp_yumi_i
   );

  mem_hdr_t hdr_r;
  logic resp_v_r;
  logic cmd_fire;

  assign cmd_ready_o = ~resp_v_r;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      resp_v_r <= 1'b0;
    else if (cmd_fire)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
      hdr_r <= cmd_i;
  end

  // Unmapped space reads as zero
  assign resp_o.header = hdr_r;
  assign resp_o.data   = '0;
  assign resp_v_o      = resp_v_r;

endmodule

/* resp_return.sv */
`timescale 1ns/1ps

module resp_return
  import mem_msg_pkg::*;
  #(parameter int num_req_p = 3)
  (  input                             clk_i
   , input                             rst_n_i

   , input  mem_msg_t                  clint_resp_i
   , input  mem_msg_t                  io_resp_i
   , input  mem_msg_t                  mem_resp_i
   , input  mem_msg_t                  loop_resp_i

   , input                             clint_v_i
   , input                             io_v_i
   , input                             mem_v_i
   , input                             loop_v_i

   , output logic                      clint_yumi_o
   , output logic                      io_yumi_o
   , output logic                      mem_yumi_o
   , output logic                      loop_yumi_o

   , output mem_msg_t [num_req_p-1:0]  req_resp_o
   , output logic     [num_req_p-1:0]  req_resp_v_o
   , input            [num_req_p-1:0]  req_resp_ready_i
   );

  logic [num_req_p-1:0] fifo_ready, fifo_push;
  logic arb_ready;
  logic [3:0] reqs, grants;
  mem_msg_t sel_resp;
  logic sel_v;

  // Only arbitrate when every queue has room for the winner
  assign arb_ready = &fifo_ready;

  // Bit 0 is highest priority, keep the lowest set bit
  assign reqs   = {loop_v_i, mem_v_i, io_v_i, clint_v_i};
  assign grants = {4{arb_ready}} & reqs & (~reqs + 4'd1);
  assign {loop_yumi_o, mem_yumi_o, io_yumi_o, clint_yumi_o} = grants;
  assign sel_v  = |grants;

  always_comb
  begin
    case (1'b1)
      grants[0]: sel_resp = clint_resp_i;
      grants[1]: sel_resp = io_resp_i;
      grants[2]: sel_resp = mem_resp_i;
      grants[3]: sel_resp = loop_resp_i;
      default:   sel_resp = '0;
    endcase
  end

  for (genvar i = 0; i < num_req_p; i++)
  begin : resp_q
    assign fifo_push[i] = sel_v & (sel_resp.header.lce_id == lce_id_t'(i));

    two_fifo
      #(.width_p($bits(mem_msg_t)))
      resp_fifo
      (.clk_i(clk_i)
       ,.rst_n_i(rst_n_i)

       ,.data_i(sel_resp)
       ,.v_i(fifo_push[i])
       ,.ready_o(fifo_ready[i])

       ,.data_o(req_resp_o[i])
       ,.v_o(req_resp_v_o[i])
       ,.yumi_i(req_resp_ready_i[i] & req_resp_v_o[i])
       );
  end

endmodule

/* uncore_top.sv */
`timescale 1ns/1ps

module uncore_top
  import mem_msg_pkg::*;
  #(parameter int num_req_p = 3)
  (  input                              clk_i
   , input                              rst_n_i

   // Requester ports
   , input  mem_msg_t [num_req_p-1:0]   req_cmd_i
   , input            [num_req_p-1:0]   req_cmd_v_i
   , output logic     [num_req_p-1:0]   req_cmd_ready_o

   , output mem_msg_t [num_req_p-1:0]   req_resp_o
   , output logic     [num_req_p-1:0]   req_resp_v_o
   , input            [num_req_p-1:0]   req_resp_ready_i

   // Outgoing I/O
   , output mem_msg_t                   io_cmd_o
   , output logic                       io_cmd_v_o
   , input                              io_cmd_ready_i

   , input  mem_msg_t                   io_resp_i
   , input                              io_resp_v_i
   , output logic                       io_resp_yumi_o

   // Memory
   , output mem_msg_t                   mem_cmd_o
   , output logic                       mem_cmd_v_o
   , input                              mem_cmd_ready_i

   , input  mem_msg_t                   mem_resp_i
   , input                              mem_resp_v_i
   , output logic                       mem_resp_yumi_o

   , output logic                       timer_irq_o
   , output logic                       software_irq_o
   );

  mem_msg_t grant_cmd;
  logic grant_v, dest_ready;

  logic clint_cmd_v, clint_cmd_ready;
  mem_msg_t clint_resp;
  logic clint_resp_v, clint_resp_yumi;

  logic loop_cmd_v, loop_cmd_ready;
  mem_msg_t loop_resp;
  logic loop_resp_v, loop_resp_yumi;

  req_ingress
    #(.num_req_p(num_req_p))
    ingress
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.req_cmd_i(req_cmd_i)
     ,.req_cmd_v_i(req_cmd_v_i)
     ,.req_cmd_ready_o(req_cmd_ready_o)
     ,.grant_cmd_o(grant_cmd)
     ,.grant_v_o(grant_v)
     ,.dest_ready_i(dest_ready)
     );

  cmd_dispatch
    dispatch
    (.cmd_v_i(grant_v)
     ,.cmd_addr_i(grant_cmd.header.addr)
     ,.clint_ready_i(clint_cmd_ready)
     ,.loop_ready_i(loop_cmd_ready)
     ,.io_ready_i(io_cmd_ready_i)
     ,.mem_ready_i(mem_cmd_ready_i)
     ,.clint_v_o(clint_cmd_v)
     ,.loop_v_o(loop_cmd_v)
     ,.io_v_o(io_cmd_v_o)
     ,.mem_v_o(mem_cmd_v_o)
     ,.dest_ready_o(dest_ready)
     );

  // Memory port is a straight pass-through, no L2
  assign io_cmd_o  = grant_cmd;
  assign mem_cmd_o = grant_cmd;

  clint_slice
    clint
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.cmd_i(grant_cmd)
     ,.cmd_v_i(clint_cmd_v)
     ,.cmd_ready_o(clint_cmd_ready)
     ,.resp_o(clint_resp)
     ,.resp_v_o(clint_resp_v)
     ,.resp_yumi_i(clint_resp_yumi)
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

  loopback_dev
    loopback
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.cmd_i(grant_cmd.header)
     ,.cmd_v_i(loop_cmd_v)
     ,.cmd_ready_o(loop_cmd_ready)
     ,.resp_o(loop_resp)
     ,.resp_v_o(loop_resp_v)
     ,.resp_yumi_i(loop_resp_yumi)
     );

  resp_return
    #(.num_req_p(num_req_p))
    ret
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.clint_resp_i(clint_resp)
     ,.io_resp_i(io_resp_i)
     ,.mem_resp_i(mem_resp_i)
     ,.loop_resp_i(loop_resp)
     ,.clint_v_i(clint_resp_v)
     ,.io_v_i(io_resp_v_i)
     ,.mem_v_i(mem_resp_v_i)
     ,.loop_v_i(loop_resp_v)
     ,.clint_yumi_o(clint_resp_yumi)
     ,.io_yumi_o(io_resp_yumi_o)
     ,.mem_yumi_o(mem_resp_yumi_o)
     ,.loop_yumi_o(loop_resp_yumi)
     ,.req_resp_o(req_resp_o)
     ,.req_resp_v_o(req_resp_v_o)
     ,.req_resp_ready_i(req_resp_ready_i)
     );

endmodule

/* tb_uncore.sv */
`timescale 1ns/1ps

module tb_uncore
  import mem_msg_pkg::*;
  import mem_map_pkg::*;
  ();

  localparam int num_req_c = 3;
  localparam int wait_limit_c = 100;

  logic clk;
  logic rst_n;

  mem_msg_t [num_req_c-1:0] req_cmd;
  logic     [num_req_c-1:0] req_cmd_v;
  logic     [num_req_c-1:0] req_cmd_ready;
  mem_msg_t [num_req_c-1:0] req_resp;
  logic     [num_req_c-1:0] req_resp_v;
  logic     [num_req_c-1:0] req_resp_ready;

  mem_msg_t io_cmd, io_resp, mem_cmd, mem_resp;
  logic io_cmd_v, io_cmd_ready, io_resp_v, io_resp_yumi;
  logic mem_cmd_v, mem_cmd_ready, mem_resp_v, mem_resp_yumi;
  logic timer_irq, software_irq;

  integer seed = 32'ha853d2f5;
  int checks = 0;
  int errors = 0;

  // Commands seen leaving the memory and I/O ports
  mem_msg_t mem_seen [$];
  mem_msg_t io_seen [$];

  uncore_top
    #(.num_req_p(num_req_c))
    DUT
    (.clk_i(clk)
     ,.rst_n_i(rst_n)
     ,.req_cmd_i(req_cmd)
     ,.req_cmd_v_i(req_cmd_v)
     ,.req_cmd_ready_o(req_cmd_ready)
     ,.req_resp_o(req_resp)
     ,.req_resp_v_o(req_resp_v)
     ,.req_resp_ready_i(req_resp_ready)
     ,.io_cmd_o(io_cmd)
     ,.io_cmd_v_o(io_cmd_v)
     ,.io_cmd_ready_i(io_cmd_ready)
     ,.io_resp_i(io_resp)
     ,.io_resp_v_i(io_resp_v)
     ,.io_resp_yumi_o(io_resp_yumi)
     ,.mem_cmd_o(mem_cmd)
     ,.mem_cmd_v_o(mem_cmd_v)
     ,.mem_cmd_ready_i(mem_cmd_ready)
     ,.mem_resp_i(mem_resp)
     ,.mem_resp_v_i(mem_resp_v)
     ,.mem_resp_yumi_o(mem_resp_yumi)
     ,.timer_irq_o(timer_irq)
     ,.software_irq_o(software_irq)
     );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic paddr_t local_addr(dev_id_t dev, paddr_t off);
    return (paddr_t'(dev) << dev_lsb_c) | off;
  endfunction

  function automatic mem_msg_t make_msg(msg_type_e t, int port, paddr_t addr, data_t data);
    mem_msg_t m;
    m.header.msg_type = t;
    m.header.lce_id   = lce_id_t'(port);
    m.header.addr     = addr;
    m.data            = data;
    return m;
  endfunction

  // Memory and I/O answer with the header and the inverted address
  function automatic mem_msg_t echo_resp(mem_msg_t cmd);
    mem_msg_t r;
    r.header = cmd.header;
    r.data   = {32'b0, ~cmd.header.addr};
    return r;
  endfunction

  initial
  begin : mem_side
    mem_msg_t pend [$];
    int delay;
    delay = 0;
    mem_resp = '0;
    mem_resp_v = 1'b0;
    forever
    begin
      @(posedge clk);
      if (mem_resp_v && mem_resp_yumi)
      begin
        pend.delete(0);
        delay = 1 + ({$random(seed)} % 4);
      end
      if (mem_cmd_v && mem_cmd_ready)
      begin
        if (pend.size() == 0)
          delay = 1 + ({$random(seed)} % 4);
        pend.push_back(mem_cmd);
        mem_seen.push_back(mem_cmd);
      end
      #1;
      if (pend.size() > 0 && delay == 0)
      begin
        mem_resp = echo_resp(pend[0]);
        mem_resp_v = 1'b1;
      end
      else
      begin
        mem_resp_v = 1'b0;
        if (delay > 0)
          delay--;
      end
    end
  end

  initial
  begin : io_side
    mem_msg_t pend [$];
    int delay;
    delay = 0;
    io_resp = '0;
    io_resp_v = 1'b0;
    forever
    begin
      @(posedge clk);
      if (io_resp_v && io_resp_yumi)
      begin
        pend.delete(0);
        delay = 1 + ({$random(seed)} % 4);
      end
      if (io_cmd_v && io_cmd_ready)
      begin
        if (pend.size() == 0)
          delay = 1 + ({$random(seed)} % 4);
        pend.push_back(io_cmd);
        io_seen.push_back(io_cmd);
      end
      #1;
      if (pend.size() > 0 && delay == 0)
      begin
        io_resp = echo_resp(pend[0]);
        io_resp_v = 1'b1;
      end
      else
      begin
        io_resp_v = 1'b0;
        if (delay > 0)
          delay--;
      end
    end
  end

  task automatic check_value(string name, logic [127:0] exp, logic [127:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
  task automatic send_cmd(int port, mem_msg_t msg);
    int n;
    logic done;
    done = 1'b0;
    req_cmd[port] = msg;
    req_cmd_v[port] = 1'b1;
    for (n = 0; n < wait_limit_c && !done; n++)
    begin
      @(posedge clk);
      done = req_cmd_ready[port];
    end
    #1;
    req_cmd_v[port] = 1'b0;
    if (!done)
    begin
      errors++;
      $display("timeout waiting for requester %0d to accept a command", port);
    end
  endtask

  task automatic wait_resp(int port, output mem_msg_t msg, output logic [num_req_c-1:0] vmask);
    int n;
    logic got;
    got = 1'b0;
    msg = '0;
    vmask = '0;
    for (n = 0; n < wait_limit_c && !got; n++)
    begin
      @(posedge clk);
      if (req_resp_v[port])
      begin
        got = 1'b1;
        msg = req_resp[port];
        vmask = req_resp_v;
      end
    end
    #1;
    if (!got)
    begin
      errors++;
      $display("timeout waiting for a response on requester %0d", port);
    end
  endtask

  task automatic wait_seen(bit use_io, output mem_msg_t msg);
    int n;
    n = 0;
    msg = '0;
    while ((use_io ? io_seen.size() : mem_seen.size()) == 0 && n < wait_limit_c)
    begin
      @(posedge clk);
      #1;
      n++;
    end
    if ((use_io ? io_seen.size() : mem_seen.size()) == 0)
    begin
      errors++;
      $display("timeout waiting for a command on the %s port", use_io ? "I/O" : "memory");
    end
    else if (use_io)
      msg = io_seen.pop_front();
    else
      msg = mem_seen.pop_front();
  endtask

  task automatic port_txn(string name, int port, msg_type_e t, paddr_t addr, data_t data,
                          bit use_io);
    mem_msg_t cmd, seen, resp;
    logic [num_req_c-1:0] vmask;
    cmd = make_msg(t, port, addr, data);
    send_cmd(port, cmd);
    wait_seen(use_io, seen);
    check_value({name, " command"}, cmd, seen);
    wait_resp(port, resp, vmask);
    check_value({name, " response"}, echo_resp(cmd), resp);
    check_value({name, " response port"}, 1 << port, vmask);
  endtask

  task automatic clint_access(string name, int port, msg_type_e t, clint_off_t off,
                              data_t wdata, output data_t rdata);
    mem_msg_t cmd, resp;
    logic [num_req_c-1:0] vmask;
    cmd = make_msg(t, port, local_addr(clint_dev_c, paddr_t'(off)), wdata);
    send_cmd(port, cmd);
    wait_resp(port, resp, vmask);
    check_value({name, " header"}, cmd.header, resp.header);
    check_value({name, " response port"}, 1 << port, vmask);
    if (t == e_mem_wr)
      check_value({name, " write data"}, 0, resp.data);
    rdata = resp.data;
  endtask

  task automatic test_reset();
    check_value("reset cmd ready", {num_req_c{1'b1}}, req_cmd_ready);
    check_value("reset resp valid", 0, req_resp_v);
    check_value("reset io cmd valid", 0, io_cmd_v);
    check_value("reset mem cmd valid", 0, mem_cmd_v);
    check_value("reset io yumi", 0, io_resp_yumi);
    check_value("reset mem yumi", 0, mem_resp_yumi);
    check_value("reset timer irq", 0, timer_irq);
    check_value("reset software irq", 0, software_irq);
  endtask

  task automatic test_mem_path();
    for (int p = 0; p < num_req_c; p++)
      port_txn("mem read", p, e_mem_rd, dram_base_c + 32'h1000 + 32'h40 * p, '0, 1'b0);
    port_txn("cache window read", 1, e_mem_rd, local_addr(cache_dev_c, 32'h120), '0, 1'b0);
  endtask

  task automatic test_io_path();
    port_txn("io write", 2, e_mem_wr, local_addr(host_dev_c, 32'h10),
             64'hdead_beef_0123_4567, 1'b1);
  endtask

  task automatic test_clint();
    data_t rd, t1, t2;
    int n;
    clint_access("mtimecmp write", 1, e_mem_wr, mtimecmp_off_c, 64'h0000_1234_5678_9abc, rd);
    clint_access("mtimecmp read", 1, e_mem_rd, mtimecmp_off_c, '0, rd);
    check_value("mtimecmp readback", 64'h0000_1234_5678_9abc, rd);
    check_value("timer irq before match", 0, timer_irq);
    clint_access("msip set", 0, e_mem_wr, msip_off_c, 64'd1, rd);
    check_value("software irq set", 1, software_irq);
    clint_access("msip read", 0, e_mem_rd, msip_off_c, '0, rd);
    check_value("msip readback", 1, rd);
    clint_access("msip clear", 0, e_mem_wr, msip_off_c, 64'd0, rd);
    check_value("software irq clear", 0, software_irq);
    clint_access("mtimecmp zero", 2, e_mem_wr, mtimecmp_off_c, 64'd0, rd);
    n = 0;
    while (!timer_irq && n < wait_limit_c)
    begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!timer_irq)
    begin
      errors++;
      $display("timeout waiting for the timer interrupt");
    end
    clint_access("mtime read 1", 2, e_mem_rd, mtime_off_c, '0, t1);
    clint_access("mtime read 2", 2, e_mem_rd, mtime_off_c, '0, t2);
    check_value("mtime advances", 1, t2 > t1);
  endtask

  task automatic test_loopback();
    mem_msg_t cmd, resp;
    logic [num_req_c-1:0] vmask;
    cmd = make_msg(e_mem_rd, 0, local_addr(4'd5, 32'h80), '0);
    send_cmd(0, cmd);
    wait_resp(0, resp, vmask);
    check_value("loopback header", cmd.header, resp.header);
    check_value("loopback data", 0, resp.data);
    check_value("loopback response port", 1, vmask);
  endtask

  task automatic test_priority();
    mem_msg_t cmd_lo, cmd_hi, seen, resp;
    logic [num_req_c-1:0] vmask;
    cmd_lo = make_msg(e_mem_rd, 2, dram_base_c + 32'h2200, '0);
    cmd_hi = make_msg(e_mem_rd, 0, dram_base_c + 32'h3300, '0);
    mem_cmd_ready = 1'b0;
    send_cmd(2, cmd_lo);
    send_cmd(0, cmd_hi);
    mem_cmd_ready = 1'b1;
    wait_seen(1'b0, seen);
    check_value("priority first", cmd_hi, seen);
    wait_seen(1'b0, seen);
    check_value("priority second", cmd_lo, seen);
    wait_resp(0, resp, vmask);
    check_value("priority resp 0", echo_resp(cmd_hi), resp);
    wait_resp(2, resp, vmask);
    check_value("priority resp 2", echo_resp(cmd_lo), resp);
  endtask

  initial
  begin
    rst_n = 1'b0;
    req_cmd = '0;
    req_cmd_v = '0;
    req_resp_ready = '1;
    io_cmd_ready = 1'b1;
    mem_cmd_ready = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_reset();
    test_mem_path();
    test_io_path();
    test_clint();
    test_loopback();
    test_priority();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  initial
  begin
    #200000;
    $display("timeout: the simulation did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* uncore_xbar.f */
mem_msg_pkg.sv
mem_map_pkg.sv
two_fifo.sv
req_ingress.sv
cmd_dispatch.sv
clint_slice.sv
loopback_dev.sv
resp_return.sv
uncore_top.sv
tb_uncore.sv

/* Bender.yml */
package:
  name: uncore_xbar

sources:
  - mem_msg_pkg.sv
  - mem_map_pkg.sv
  - two_fifo.sv
  - req_ingress.sv
  - cmd_dispatch.sv
  - clint_slice.sv
  - loopback_dev.sv
  - resp_return.sv
  - uncore_top.sv
  - target: simulation
    files:
      - tb_uncore.sv
